// ==== hw/mask_alu_pkg.sv ====
package mask_alu_pkg;

  localparam int VLEN            = 128;
  localparam int VLENB           = VLEN / 8;
  localparam int XLEN            = 32;
  localparam int BYTE_WIDTH      = 8;
  localparam int HWORD_WIDTH     = 16;
  localparam int WORD_WIDTH      = 32;
  localparam int ROB_DEPTH_WIDTH = 3;
  localparam int VSTART_WIDTH    = 7;
  // vl needs one more bit to reach VLEN
  localparam int VL_WIDTH        = 8;
  localparam int UOP_INDEX_WIDTH = 3;
  localparam int IDX_WIDTH       = $clog2(VLEN);
  localparam int FUNCT6_WIDTH    = 6;
  localparam int FUNCT3_WIDTH    = 3;
  localparam int VS1_WIDTH       = 5;

  localparam logic [FUNCT3_WIDTH-1:0] FUNCT3_OPMVV = 3'b010;

  // mask logicals
  localparam logic [FUNCT6_WIDTH-1:0] VMANDN    = 6'b011000;
  localparam logic [FUNCT6_WIDTH-1:0] VMAND     = 6'b011001;
  localparam logic [FUNCT6_WIDTH-1:0] VMOR      = 6'b011010;
  localparam logic [FUNCT6_WIDTH-1:0] VMXOR     = 6'b011011;
  localparam logic [FUNCT6_WIDTH-1:0] VMORN     = 6'b011100;
  localparam logic [FUNCT6_WIDTH-1:0] VMNAND    = 6'b011101;
  localparam logic [FUNCT6_WIDTH-1:0] VMNOR     = 6'b011110;
  localparam logic [FUNCT6_WIDTH-1:0] VMXNOR    = 6'b011111;
  localparam logic [FUNCT6_WIDTH-1:0] VWXUNARY0 = 6'b010000;
  localparam logic [FUNCT6_WIDTH-1:0] VMUNARY0  = 6'b010100;

  // vs1 field selects the unary op
  localparam logic [VS1_WIDTH-1:0] VCPOP  = 5'b10000;
  localparam logic [VS1_WIDTH-1:0] VFIRST = 5'b10001;
  localparam logic [VS1_WIDTH-1:0] VMSBF  = 5'b00001;
  localparam logic [VS1_WIDTH-1:0] VMSOF  = 5'b00010;
  localparam logic [VS1_WIDTH-1:0] VMSIF  = 5'b00011;
  localparam logic [VS1_WIDTH-1:0] VIOTA  = 5'b10000;
  localparam logic [VS1_WIDTH-1:0] VID    = 5'b10001;

  typedef enum logic [1:0] {
    EEW8  = 2'b00,
    EEW16 = 2'b01,
    EEW32 = 2'b10
  } eew_e;

  typedef enum logic [4:0] {
    OP_NONE, OP_ANDN, OP_AND, OP_OR, OP_XOR, OP_ORN, OP_NAND, OP_NOR, OP_XNOR,
    OP_CPOP, OP_FIRST, OP_SBF, OP_SIF, OP_SOF, OP_IOTA, OP_ID
  } mask_op_e;

  typedef struct packed {
    logic [ROB_DEPTH_WIDTH-1:0] rob_entry;
    logic [FUNCT6_WIDTH-1:0]    funct6;
    logic [FUNCT3_WIDTH-1:0]    funct3;
    logic [VS1_WIDTH-1:0]       vs1;
    logic [VSTART_WIDTH-1:0]    vstart;
    logic [VL_WIDTH-1:0]        vl;
    logic                       vm;
    logic [VLEN-1:0]            v0_data;
    logic                       v0_data_valid;
    logic [VLEN-1:0]            vd_data;
    logic                       vd_data_valid;
    logic [VLEN-1:0]            vs1_data;
    logic                       vs1_data_valid;
    logic [VLEN-1:0]            vs2_data;
    logic                       vs2_data_valid;
    eew_e                       vd_eew;
    logic [UOP_INDEX_WIDTH-1:0] uop_index;
  } mask_uop_t;

  typedef struct packed {
    logic [ROB_DEPTH_WIDTH-1:0] rob_entry;
    logic [VLEN-1:0]            w_data;
  } mask_result_t;

endpackage

// ==== hw/mask_logic_op.sv ====
`timescale 1ns/1ps

module mask_logic_op
  import mask_alu_pkg::*;
(
  input  mask_op_e                op,
  input  logic [VLEN-1:0]         vs2_data,
  input  logic [VLEN-1:0]         vs1_data,
  input  logic [VLEN-1:0]         vd_data,
  input  logic [VSTART_WIDTH-1:0] vstart,
  output logic [VLEN-1:0]         data
);

  logic [VLEN-1:0] func_data;

  always_comb begin
    case (op)
      OP_ANDN: func_data = vs2_data & ~vs1_data;
      OP_AND:  func_data = vs2_data & vs1_data;
      OP_OR:   func_data = vs2_data | vs1_data;
      OP_XOR:  func_data = vs2_data ^ vs1_data;
      OP_ORN:  func_data = vs2_data | ~vs1_data;
      OP_NAND: func_data = ~(vs2_data & vs1_data);
      OP_NOR:  func_data = ~(vs2_data | vs1_data);
      OP_XNOR: func_data = ~(vs2_data ^ vs1_data);
      default: func_data = '0;
    endcase
  end

  // prestart bits keep the old destination
  always_comb begin
    for (int i = 0; i < VLEN; i++) begin
      if (i < vstart) begin
        data[i] = vd_data[i];
      end else begin
        data[i] = func_data[i];
      end
    end
  end

endmodule

// ==== hw/mask_scan.sv ====
`timescale 1ns/1ps

module mask_scan
  import mask_alu_pkg::*;
(
  input  mask_op_e            op,
  input  logic [VLEN-1:0]     vs2_data,
  input  logic [VLEN-1:0]     v0_data,
  input  logic [VLEN-1:0]     vd_data,
  input  logic                vm,
  input  logic [VL_WIDTH-1:0] vl,
  output logic [VLEN-1:0]     data
);

  logic [VLEN-1:0]      tail_mask;
  logic [VLEN-1:0]      active_mask;
  logic [VLEN-1:0]      count_src;
  logic [VLEN-1:0]      set_src;
  logic [VLEN-1:0]      first_one;
  logic [VLEN-1:0]      sbf_mask;
  logic [VLEN-1:0]      set_mask;
  logic [XLEN-1:0]      pop_cnt;
  logic [IDX_WIDTH-1:0] first_idx;

  always_comb begin
    for (int i = 0; i < VLEN; i++) begin
      tail_mask[i] = i < vl;
    end
  end

  assign active_mask = vm ? '1 : v0_data;
  assign count_src   = vs2_data & tail_mask & active_mask;
  // no tail mask for the set-first family
  assign set_src     = vs2_data & active_mask;

  // popcount per byte group, then summed
  always_comb begin
    logic [$clog2(BYTE_WIDTH):0] byte_cnt;
    pop_cnt = '0;
    for (int g = 0; g < VLENB; g++) begin
      byte_cnt = '0;
      for (int b = 0; b < BYTE_WIDTH; b++) begin
        byte_cnt = byte_cnt + count_src[g*BYTE_WIDTH+b];
      end
      pop_cnt = pop_cnt + XLEN'(byte_cnt);
    end
  end

  // scan downward so the lowest set bit wins
  always_comb begin
    first_idx = '0;
    for (int i = VLEN - 1; i >= 0; i--) begin
      if (count_src[i]) begin
        first_idx = IDX_WIDTH'(i);
      end
    end
  end

  assign first_one = set_src & (~set_src + 1'b1);
  assign sbf_mask  = first_one - 1'b1;

  always_comb begin
    case (op)
      OP_SBF:  set_mask = sbf_mask;
      OP_SIF:  set_mask = sbf_mask | first_one;
      default: set_mask = first_one;
    endcase
    // no set bit at all gives all ones
    if (set_src == '0) begin
      set_mask = '1;
    end
  end

  always_comb begin
    case (op)
      OP_CPOP:  data = VLEN'(pop_cnt);
      OP_FIRST: data = (count_src == '0) ? '1 : VLEN'(first_idx);
      OP_SBF, OP_SIF, OP_SOF: data = (set_mask & active_mask) | (vd_data & ~active_mask);
      default:  data = '0;
    endcase
  end

endmodule

// ==== hw/mask_index_gen.sv ====
`timescale 1ns/1ps

module mask_index_gen
  import mask_alu_pkg::*;
(
  input  mask_op_e                   op,
  input  logic [VLEN-1:0]            vs2_data,
  input  logic [VLEN-1:0]            v0_data,
  input  logic                       vm,
  input  eew_e                       vd_eew,
  input  logic [UOP_INDEX_WIDTH-1:0] uop_index,
  output logic [VLEN-1:0]            data
);

  logic [VLEN-1:0]                 src_masked;
  logic [VLEN-1:0]                 iota_src;
  logic [VLEN-1:0][IDX_WIDTH-1:0]  iota_cnt;
  logic [VLEN-1:0]                 iota_word;
  logic [VLEN-1:0]                 id_word;

  // global element index of position pos in this uop
  function automatic logic [IDX_WIDTH-1:0] elem_index(
    input logic [UOP_INDEX_WIDTH-1:0] uidx,
    input int                         pos,
    input int                         elems
  );
    elem_index = IDX_WIDTH'(uidx * elems + pos);
  endfunction

  assign src_masked = vm ? vs2_data : vs2_data & v0_data;
  // shifted so an inclusive prefix counts bits strictly below
  assign iota_src   = {src_masked[VLEN-2:0], 1'b0};

  // prefix count inside each byte, offset by the groups below
  always_comb begin
    logic [IDX_WIDTH-1:0]        base;
    logic [$clog2(BYTE_WIDTH):0] run;
    base = '0;
    for (int g = 0; g < VLENB; g++) begin
      run = '0;
      for (int b = 0; b < BYTE_WIDTH; b++) begin
        run = run + iota_src[g*BYTE_WIDTH+b];
        iota_cnt[g*BYTE_WIDTH+b] = base + IDX_WIDTH'(run);
      end
      base = base + IDX_WIDTH'(run);
    end
  end

  always_comb begin
    iota_word = '0;
    id_word   = '0;
    case (vd_eew)
      EEW8: begin
        for (int e = 0; e < VLEN / BYTE_WIDTH; e++) begin
          iota_word[e*BYTE_WIDTH +: BYTE_WIDTH] =
            BYTE_WIDTH'(iota_cnt[elem_index(uop_index, e, VLEN / BYTE_WIDTH)]);
          id_word[e*BYTE_WIDTH +: BYTE_WIDTH] =
            BYTE_WIDTH'(elem_index(uop_index, e, VLEN / BYTE_WIDTH));
        end
      end
      EEW16: begin
        for (int e = 0; e < VLEN / HWORD_WIDTH; e++) begin
          iota_word[e*HWORD_WIDTH +: HWORD_WIDTH] =
            HWORD_WIDTH'(iota_cnt[elem_index(uop_index, e, VLEN / HWORD_WIDTH)]);
          id_word[e*HWORD_WIDTH +: HWORD_WIDTH] =
            HWORD_WIDTH'(elem_index(uop_index, e, VLEN / HWORD_WIDTH));
        end
      end
      EEW32: begin
        for (int e = 0; e < VLEN / WORD_WIDTH; e++) begin
          iota_word[e*WORD_WIDTH +: WORD_WIDTH] =
            WORD_WIDTH'(iota_cnt[elem_index(uop_index, e, VLEN / WORD_WIDTH)]);
          id_word[e*WORD_WIDTH +: WORD_WIDTH] =
            WORD_WIDTH'(elem_index(uop_index, e, VLEN / WORD_WIDTH));
        end
      end
      default: begin
        iota_word = '0;
      end
    endcase
  end

  always_comb begin
    case (op)
      OP_IOTA: data = iota_word;
      OP_ID:   data = id_word;
      default: data = '0;
    endcase
  end

endmodule

// ==== hw/mask_alu_unit.sv ====
`timescale 1ns/1ps

module mask_alu_unit
  import mask_alu_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         alu_uop_valid,
  input  mask_uop_t    alu_uop,
  output logic         result_valid,
  output mask_result_t result
);

  mask_op_e        op;
  logic            operand_ok;
  logic [VLEN-1:0] logic_data;
  logic [VLEN-1:0] scan_data;
  logic [VLEN-1:0] index_data;
  logic [VLEN-1:0] w_data;

  // only OPMVV carries mask ops
  always_comb begin
    op = OP_NONE;
    if (alu_uop.funct3 == FUNCT3_OPMVV) begin
      case (alu_uop.funct6)
        VMANDN: op = OP_ANDN;
        VMAND:  op = OP_AND;
        VMOR:   op = OP_OR;
        VMXOR:  op = OP_XOR;
        VMORN:  op = OP_ORN;
        VMNAND: op = OP_NAND;
        VMNOR:  op = OP_NOR;
        VMXNOR: op = OP_XNOR;
        VWXUNARY0: begin
          case (alu_uop.vs1)
            VCPOP:   op = OP_CPOP;
            VFIRST:  op = OP_FIRST;
            default: op = OP_NONE;
          endcase
        end
        VMUNARY0: begin
          case (alu_uop.vs1)
            VMSBF:   op = OP_SBF;
            VMSIF:   op = OP_SIF;
            VMSOF:   op = OP_SOF;
            VIOTA:   op = OP_IOTA;
            VID:     op = OP_ID;
            default: op = OP_NONE;
          endcase
        end
        default: op = OP_NONE;
      endcase
    end
  end

  // operand readiness per op class
  always_comb begin
    case (op)
      OP_ANDN, OP_AND, OP_OR, OP_XOR, OP_ORN, OP_NAND, OP_NOR, OP_XNOR:
        operand_ok = alu_uop.vs1_data_valid & alu_uop.vs2_data_valid & alu_uop.vm &
                     alu_uop.vd_data_valid;
      OP_CPOP, OP_FIRST, OP_IOTA:
        operand_ok = !alu_uop.vs1_data_valid & alu_uop.vs2_data_valid &
                     (alu_uop.vm | alu_uop.v0_data_valid);
      OP_SBF, OP_SIF, OP_SOF:
        operand_ok = !alu_uop.vs1_data_valid & alu_uop.vs2_data_valid &
                     (alu_uop.vm | (alu_uop.vd_data_valid & alu_uop.v0_data_valid));
      OP_ID:   operand_ok = 1'b1;
      default: operand_ok = 1'b0;
    endcase
  end

  mask_logic_op u_mask_logic_op (
    .op       (op),
    .vs2_data (alu_uop.vs2_data),
    .vs1_data (alu_uop.vs1_data),
    .vd_data  (alu_uop.vd_data),
    .vstart   (alu_uop.vstart),
    .data     (logic_data)
  );

  mask_scan u_mask_scan (
    .op       (op),
    .vs2_data (alu_uop.vs2_data),
    .v0_data  (alu_uop.v0_data),
    .vd_data  (alu_uop.vd_data),
    .vm       (alu_uop.vm),
    .vl       (alu_uop.vl),
    .data     (scan_data)
  );

  mask_index_gen u_mask_index_gen (
    .op        (op),
    .vs2_data  (alu_uop.vs2_data),
    .v0_data   (alu_uop.v0_data),
    .vm        (alu_uop.vm),
    .vd_eew    (alu_uop.vd_eew),
    .uop_index (alu_uop.uop_index),
    .data      (index_data)
  );

  always_comb begin
    case (op)
      OP_ANDN, OP_AND, OP_OR, OP_XOR, OP_ORN, OP_NAND, OP_NOR, OP_XNOR:
        w_data = logic_data;
      OP_CPOP, OP_FIRST, OP_SBF, OP_SIF, OP_SOF:
        w_data = scan_data;
      OP_IOTA, OP_ID:
        w_data = index_data;
      default: w_data = '0;
    endcase
  end

  // invalid slots go out as zero
  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid <= 1'b0;
      result       <= '0;
    end else begin
      result_valid <= alu_uop_valid & operand_ok;
      if (alu_uop_valid & operand_ok) begin
        result.rob_entry <= alu_uop.rob_entry;
        result.w_data    <= w_data;
      end else begin
        result <= '0;
      end
    end
  end

endmodule

// ==== tb/mask_alu_assertions.sv ====
`timescale 1ns/1ps

module mask_alu_assertions
  import mask_alu_pkg::*;
(
  input logic         clk,
  input logic         reset,
  input logic         alu_uop_valid,
  input logic         result_valid,
  input mask_result_t result
);

  int fail_count = 0;

  property valid_low_after_reset;
    @(posedge clk) reset |=> !result_valid;
  endproperty

  property valid_follows_uop_valid;
    @(posedge clk) disable iff (reset) !alu_uop_valid |=> !result_valid;
  endproperty

  // idle slots carry no stale data
  property result_zero_when_idle;
    @(posedge clk) disable iff (reset) !result_valid |-> result == '0;
  endproperty

  assert property (valid_low_after_reset)
    else begin
      $error("result_valid high in the cycle after reset");
      fail_count++;
    end
  assert property (valid_follows_uop_valid)
    else begin
      $error("result_valid high one cycle after alu_uop_valid was low");
      fail_count++;
    end
  assert property (result_zero_when_idle)
    else begin
      $error("result not zero while result_valid is low");
      fail_count++;
    end

endmodule

bind mask_alu_unit mask_alu_assertions u_mask_alu_assertions (
  .clk           (clk),
  .reset         (reset),
  .alu_uop_valid (alu_uop_valid),
  .result_valid  (result_valid),
  .result        (result)
);

// ==== tb/mask_alu_tb.sv ====
`timescale 1ns/1ps

module mask_alu_tb
  import mask_alu_pkg::*;
;

  localparam int CLK_PERIOD     = 100;
  localparam int RESET_CYCLES   = 10;
  localparam int SEED           = 23259;
  // uops issued over all tests
  localparam int NUM_UOPS       = 108;
  localparam int TIMEOUT_CYCLES = NUM_UOPS * 4 + RESET_CYCLES;

  logic         clk;
  logic         reset;
  logic         alu_uop_valid;
  mask_uop_t    alu_uop;
  logic         result_valid;
  mask_result_t result;
  int           checks;
  int           errors;

  mask_alu_unit u_mask_alu_unit (
    .clk           (clk),
    .reset         (reset),
    .alu_uop_valid (alu_uop_valid),
    .alu_uop       (alu_uop),
    .result_valid  (result_valid),
    .result        (result)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("watchdog expired before the tests finished");
    $display("** FAIL **");
    $finish;
  end

  function automatic logic [VLEN-1:0] rand_vec();
    return {$urandom(), $urandom(), $urandom(), $urandom()};
  endfunction

  function automatic int eew_bits(input eew_e eew);
    case (eew)
      EEW8:    return 8;
      EEW16:   return 16;
      default: return 32;
    endcase
  endfunction

  // random operands, unary operand valids
  function automatic mask_uop_t base_uop(input logic [FUNCT6_WIDTH-1:0] funct6,
                                         input logic [VS1_WIDTH-1:0] vs1);
    mask_uop_t u;
    u                = '0;
    u.rob_entry      = ROB_DEPTH_WIDTH'($urandom());
    u.funct6         = funct6;
    u.funct3         = FUNCT3_OPMVV;
    u.vs1            = vs1;
    u.vl             = VL_WIDTH'(VLEN);
    u.vm             = 1'b1;
    u.v0_data        = rand_vec();
    u.v0_data_valid  = 1'b1;
    u.vd_data        = rand_vec();
    u.vd_data_valid  = 1'b1;
    u.vs1_data       = rand_vec();
    u.vs2_data       = rand_vec();
    u.vs2_data_valid = 1'b1;
    u.vd_eew         = EEW8;
    return u;
  endfunction

  task automatic apply_and_check(input string name, input mask_uop_t uop, input logic valid,
                                 input logic exp_valid, input logic [VLEN-1:0] exp_data);
    logic [VLEN-1:0]            exp_word;
    logic [ROB_DEPTH_WIDTH-1:0] exp_rob;
    @(negedge clk);
    alu_uop       = uop;
    alu_uop_valid = valid;
    // registered one rising edge later
    @(negedge clk);
    exp_word = exp_valid ? exp_data : '0;
    exp_rob  = exp_valid ? uop.rob_entry : '0;
    checks++;
    assert (result_valid === exp_valid) else begin
      $display("Fail %s result_valid expected %b actual %b", name, exp_valid, result_valid);
      errors++;
    end
    assert (result.w_data === exp_word) else begin
      $display("Fail %s w_data expected %h actual %h", name, exp_word, result.w_data);
      errors++;
    end
    assert (result.rob_entry === exp_rob) else begin
      $display("Fail %s rob_entry expected %h actual %h", name, exp_rob, result.rob_entry);
      errors++;
    end
  endtask

  task automatic logical_ops();
    logic [FUNCT6_WIDTH-1:0] codes [8] = '{VMANDN, VMAND, VMOR, VMXOR,
                                           VMORN, VMNAND, VMNOR, VMXNOR};
    string                   names [8] = '{"vmandn", "vmand", "vmor", "vmxor",
                                           "vmorn", "vmnand", "vmnor", "vmxnor"};
    mask_uop_t               uop;
    logic [VLEN-1:0]         exp;
    logic                    a;
    logic                    b;
    for (int k = 0; k < 8; k++) begin
      for (int rep = 0; rep < 4; rep++) begin
        uop                = base_uop(codes[k], 5'd0);
        uop.vs1_data_valid = 1'b1;
        uop.vstart         = VSTART_WIDTH'($urandom_range(0, VLEN - 1));
        for (int i = 0; i < VLEN; i++) begin
          a = uop.vs2_data[i];
          b = uop.vs1_data[i];
          case (k)
            0: exp[i] = a & ~b;
            1: exp[i] = a & b;
            2: exp[i] = a | b;
            3: exp[i] = a ^ b;
            4: exp[i] = a | ~b;
            5: exp[i] = ~(a & b);
            6: exp[i] = ~(a | b);
            default: exp[i] = ~(a ^ b);
          endcase
          if (i < uop.vstart) begin
            exp[i] = uop.vd_data[i];
          end
        end
        apply_and_check(names[k], uop, 1'b1, 1'b1, exp);
      end
    end
  endtask

  task automatic count_and_find();
    mask_uop_t       uop;
    logic [VLEN-1:0] exp;
    int              cnt;
    int              first;
    for (int k = 0; k < 2; k++) begin
      for (int rep = 0; rep < 8; rep++) begin
        uop    = base_uop(VWXUNARY0, (k == 0) ? VCPOP : VFIRST);
        uop.vm = rep[0];
        uop.vl = VL_WIDTH'($urandom_range(0, VLEN));
        cnt    = 0;
        first  = -1;
        for (int i = 0; i < VLEN; i++) begin
          if (i < uop.vl && uop.vs2_data[i] && (uop.vm || uop.v0_data[i])) begin
            cnt++;
            if (first < 0) begin
              first = i;
            end
          end
        end
        if (k == 0) begin
          exp = VLEN'(cnt);
        end else begin
          exp = (first < 0) ? '1 : VLEN'(first);
        end
        apply_and_check((k == 0) ? "vcpop" : "vfirst", uop, 1'b1, 1'b1, exp);
      end
    end
    // nothing set means all ones
    uop          = base_uop(VWXUNARY0, VFIRST);
    uop.vs2_data = '0;
    apply_and_check("vfirst zero source", uop, 1'b1, 1'b1, '1);
  endtask

  task automatic set_first_masks();
    logic [VS1_WIDTH-1:0] codes [3] = '{VMSBF, VMSIF, VMSOF};
    string                names [3] = '{"vmsbf", "vmsif", "vmsof"};
    mask_uop_t            uop;
    logic [VLEN-1:0]      exp;
    int                   first;
    for (int k = 0; k < 3; k++) begin
      for (int rep = 0; rep < 9; rep++) begin
        uop    = base_uop(VMUNARY0, codes[k]);
        uop.vm = rep[0];
        // sparse source so the first one lands anywhere
        uop.vs2_data = (rand_vec() & rand_vec() & rand_vec()) << $urandom_range(0, 96);
        if (rep == 8) begin
          uop.vs2_data = '0;
        end
        first = -1;
        for (int i = 0; i < VLEN; i++) begin
          if (first < 0 && uop.vs2_data[i] && (uop.vm || uop.v0_data[i])) begin
            first = i;
          end
        end
        for (int i = 0; i < VLEN; i++) begin
          if (!uop.vm && !uop.v0_data[i]) begin
            exp[i] = uop.vd_data[i];
          end else if (first < 0) begin
            exp[i] = 1'b1;
          end else if (k == 0) begin
            exp[i] = i < first;
          end else if (k == 1) begin
            exp[i] = i <= first;
          end else begin
            exp[i] = i == first;
          end
        end
        apply_and_check(names[k], uop, 1'b1, 1'b1, exp);
      end
    end
  endtask

  // iota when counting, vid otherwise
  task automatic element_values(input logic is_iota);
    int              uidx [4] = '{0, 1, 3, 7};
    mask_uop_t       uop;
    logic [VLEN-1:0] exp;
    int              width;
    int              elems;
    int              idx;
    int              val;
    for (int e = 0; e < 3; e++) begin
      for (int u = 0; u < 4; u++) begin
        uop           = base_uop(VMUNARY0, is_iota ? VIOTA : VID);
        uop.vd_eew    = eew_e'(e);
        uop.uop_index = UOP_INDEX_WIDTH'(uidx[u]);
        uop.vm        = is_iota ? u[0] : 1'b1;
        width         = eew_bits(uop.vd_eew);
        elems         = VLEN / width;
        for (int el = 0; el < elems; el++) begin
          idx = uidx[u] * elems + el;
          val = idx;
          if (is_iota) begin
            val = 0;
            for (int i = 0; i < idx; i++) begin
              if (uop.vs2_data[i] && (uop.vm || uop.v0_data[i])) begin
                val++;
              end
            end
          end
          for (int b = 0; b < width; b++) begin
            exp[el*width+b] = val[b];
          end
        end
        apply_and_check(is_iota ? "viota" : "vid", uop, 1'b1, 1'b1, exp);
      end
    end
  endtask

  task automatic invalid_uops();
    mask_uop_t uop;
    uop               = base_uop(VMAND, 5'd0);
    uop.vs1_data_valid = 1'b1;
    uop.vd_data_valid  = 1'b0;
    apply_and_check("vmand without vd", uop, 1'b1, 1'b0, '0);
    uop.vd_data_valid  = 1'b1;
    uop.vm             = 1'b0;
    apply_and_check("vmand with vm low", uop, 1'b1, 1'b0, '0);
    uop               = base_uop(VWXUNARY0, VCPOP);
    uop.vm            = 1'b0;
    uop.v0_data_valid = 1'b0;
    apply_and_check("vcpop without v0", uop, 1'b1, 1'b0, '0);
    uop               = base_uop(VMUNARY0, VMSBF);
    uop.vm            = 1'b0;
    uop.vd_data_valid = 1'b0;
    apply_and_check("vmsbf without vd", uop, 1'b1, 1'b0, '0);
    uop                = base_uop(VMUNARY0, VIOTA);
    uop.vs1_data_valid = 1'b1;
    apply_and_check("viota with vs1 valid", uop, 1'b1, 1'b0, '0);
    uop                = base_uop(VWXUNARY0, VFIRST);
    uop.vs2_data_valid = 1'b0;
    apply_and_check("vfirst without vs2", uop, 1'b1, 1'b0, '0);
    uop = base_uop(6'b000000, 5'd0);
    apply_and_check("unknown funct6", uop, 1'b1, 1'b0, '0);
    uop = base_uop(VMUNARY0, VID);
    apply_and_check("uop valid low", uop, 1'b0, 1'b0, '0);
  endtask

  initial begin
    void'($urandom(SEED));
    reset         = 1'b1;
    alu_uop_valid = 1'b0;
    alu_uop       = '0;
    checks        = 0;
    errors        = 0;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    logical_ops();
    count_and_find();
    set_first_masks();
    element_values(1'b1);
    element_values(1'b0);
    invalid_uops();
    @(negedge clk);
    alu_uop_valid = 1'b0;
    @(negedge clk);
    $display("uops checked: %0d, errors: %0d, assertion failures: %0d", checks, errors,
             u_mask_alu_unit.u_mask_alu_assertions.fail_count);
    if (errors == 0 && u_mask_alu_unit.u_mask_alu_assertions.fail_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== mask_alu.f ====
hw/mask_alu_pkg.sv
hw/mask_logic_op.sv
hw/mask_scan.sv
hw/mask_index_gen.sv
hw/mask_alu_unit.sv
tb/mask_alu_assertions.sv
tb/mask_alu_tb.sv
